// ==== design/i3c_regf_pkg.sv ====
// Register file geometry, register map, reset image values and FSM state types
package i3c_regf_pkg;

  // ========================================
  // Array geometry
  // ========================================
  localparam int REGF_WIDTH  = 8;     // Bits per entry
  localparam int REGF_DEPTH  = 1024;  // Number of entries
  localparam int REGF_ADDR_W = 10;    // Entry index width

  // ========================================
  // Register map
  // ========================================
  localparam logic [REGF_ADDR_W-1:0] ADDR_TARGET        = 10'd0;    // Bit 0 is RnW
  localparam logic [REGF_ADDR_W-1:0] ADDR_NUM_FRAMES    = 10'd1;
  localparam logic [REGF_ADDR_W-1:0] ADDR_DATA_BASE     = 10'd2;    // First SDR data byte
  localparam logic [REGF_ADDR_W-1:0] ADDR_TGTS_COUNT    = 10'd35;
  localparam logic [REGF_ADDR_W-1:0] ADDR_BDCST_WR      = 10'd46;   // 7E broadcast
  localparam logic [REGF_ADDR_W-1:0] ADDR_ARBITRATION   = 10'd48;
  localparam logic [REGF_ADDR_W-1:0] ADDR_ENTDAA_CCC    = 10'd49;
  localparam logic [REGF_ADDR_W-1:0] ADDR_IBI_CFG       = 10'd101;
  localparam logic [REGF_ADDR_W-1:0] ADDR_IBI_PAYLOAD   = 10'd102;
  localparam logic [REGF_ADDR_W-1:0] ADDR_DISEC_DIR_CCC = 10'd103;
  localparam logic [REGF_ADDR_W-1:0] ADDR_CRHDLY        = 10'd383;
  localparam logic [REGF_ADDR_W-1:0] ADDR_CRCAPS2       = 10'd386;
  localparam logic [REGF_ADDR_W-1:0] ADDR_GETSTATUS_CCC = 10'd387;
  localparam logic [REGF_ADDR_W-1:0] ADDR_PRECR         = 10'd388;
  localparam logic [REGF_ADDR_W-1:0] ADDR_GETSTATUS_LSB = 10'd390;
  localparam logic [REGF_ADDR_W-1:0] ADDR_ENEC_BYTE     = 10'd402;
  localparam logic [REGF_ADDR_W-1:0] ADDR_DISEC_BYTE    = 10'd404;
  localparam logic [REGF_ADDR_W-1:0] ADDR_HJ_CFG        = 10'd405;
  localparam logic [REGF_ADDR_W-1:0] ADDR_CRH_CFG       = 10'd407;
  localparam logic [REGF_ADDR_W-1:0] ADDR_CRCAP1        = 10'd409;

  // ========================================
  // Reset image
  // ========================================
  localparam logic [REGF_WIDTH-1:0] RST_TARGET        = 8'hA8;  // Address 54, write
  localparam logic [REGF_WIDTH-1:0] RST_NUM_FRAMES    = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_DATA0         = 8'h01;
  localparam logic [REGF_WIDTH-1:0] RST_DATA1         = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_DATA2         = 8'h06;
  localparam logic [REGF_WIDTH-1:0] RST_TGTS_COUNT    = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_BDCST_WR      = 8'hFD;
  localparam logic [REGF_WIDTH-1:0] RST_ARBITRATION   = 8'h53;
  localparam logic [REGF_WIDTH-1:0] RST_ENTDAA        = 8'h07;  // CCC code
  localparam logic [REGF_WIDTH-1:0] RST_IBI_CFG       = 8'h01;  // ACK with MDB
  localparam logic [REGF_WIDTH-1:0] RST_IBI_PAYLOAD   = 8'h03;
  localparam logic [REGF_WIDTH-1:0] RST_DISEC_DIR     = 8'h81;  // CCC code
  localparam logic [REGF_WIDTH-1:0] RST_CRHDLY        = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_CRCAPS2       = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_GETSTATUS     = 8'h90;  // CCC code
  localparam logic [REGF_WIDTH-1:0] RST_PRECR         = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_GETSTATUS_LSB = 8'h02;
  localparam logic [REGF_WIDTH-1:0] RST_ENEC          = 8'h0B;  // ENINT, ENCR, ENHJ
  localparam logic [REGF_WIDTH-1:0] RST_DISEC         = 8'h00;
  localparam logic [REGF_WIDTH-1:0] RST_HJ_CFG        = 8'h07;
  localparam logic [REGF_WIDTH-1:0] RST_CRH_CFG       = 8'h01;
  localparam logic [REGF_WIDTH-1:0] RST_CRCAP1        = 8'h00;

  localparam int HJ_BIT         = 3;  // ENHJ / DISHJ defining bit
  localparam int HJ_ENABLE_BIT  = 1;  // In HJ_CFG
  localparam int HJ_SUPPORT_BIT = 0;  // In CRCAP1

  // State types
  typedef enum logic [2:0] {FS_IDLE, FS_RD_TARGET, FS_RD_DATA, FS_WAIT_DATA, FS_SEND, FS_DONE}
    fetch_state_e;
  typedef enum logic [1:0] {AS_IDLE, AS_REQ, AS_RESP} apb_state_e;

endpackage

// ==== design/regf_port_if.sv ====
// Single register file access port with requester and file modports
`timescale 1ns/1ps

interface regf_port_if;
  import i3c_regf_pkg::*;

  logic                   rd_en;     // Read request, data next cycle
  logic                   wr_en;     // Write request, takes effect at edge
  logic [REGF_ADDR_W-1:0] addr;      // Entry index
  logic [REGF_WIDTH-1:0]  wdata;
  logic [REGF_WIDTH-1:0]  rdata;     // Holds until next read
  logic                   host_gnt;  // Request passed this cycle

  modport requester (
    output rd_en, wr_en, addr, wdata,
    input  rdata, host_gnt
  );

  modport file (
    input  rd_en, wr_en, addr, wdata,
    output rdata, host_gnt
  );

endinterface

// ==== design/reg_file.sv ====
// I3C register file: storage with reset image, access port, config mirrors, hot-join bits
`timescale 1ns/1ps

module reg_file (
  input  logic                                i_regf_clk,
  input  logic                                i_regf_rst_n,
  regf_port_if.file                           port,
  output logic                                o_ser_rx_tx,              // Target RnW bit
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_regf_num_frames,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_crh_crhdly,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_crh_getstatus_data,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_crh_crcap2,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_crh_precr,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_crh_cfg_reg,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_crh_tgts_count,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_regf_ibi_cfg,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_regf_ibi_payload_size,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_ibi_tgt_address,      // Arbitration address
  output logic [2:0]                          o_regf_hj_cfg,
  output logic                                o_regf_hj_support
);
  import i3c_regf_pkg::*;

  logic [REGF_WIDTH-1:0] regs [REGF_DEPTH];
  logic                  hj_on;  // Hot-join supported and enabled

  assign hj_on = regs[ADDR_CRCAP1][HJ_SUPPORT_BIT] & regs[ADDR_HJ_CFG][HJ_ENABLE_BIT];

  // ========================================
  // Storage and access port
  // ========================================
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      for (int i = 0; i < REGF_DEPTH; i++)
        regs[i] <= '0;                                   // Unlisted entries clear
      regs[ADDR_TARGET]            <= RST_TARGET;
      regs[ADDR_NUM_FRAMES]        <= RST_NUM_FRAMES;
      regs[ADDR_DATA_BASE]         <= RST_DATA0;
      regs[ADDR_DATA_BASE + 10'd1] <= RST_DATA1;
      regs[ADDR_DATA_BASE + 10'd2] <= RST_DATA2;
      regs[ADDR_TGTS_COUNT]        <= RST_TGTS_COUNT;
      regs[ADDR_BDCST_WR]          <= RST_BDCST_WR;
      regs[ADDR_ARBITRATION]       <= RST_ARBITRATION;
      regs[ADDR_ENTDAA_CCC]        <= RST_ENTDAA;
      regs[ADDR_IBI_CFG]           <= RST_IBI_CFG;
      regs[ADDR_IBI_PAYLOAD]       <= RST_IBI_PAYLOAD;
      regs[ADDR_DISEC_DIR_CCC]     <= RST_DISEC_DIR;
      regs[ADDR_CRHDLY]            <= RST_CRHDLY;
      regs[ADDR_CRCAPS2]           <= RST_CRCAPS2;
      regs[ADDR_GETSTATUS_CCC]     <= RST_GETSTATUS;
      regs[ADDR_PRECR]             <= RST_PRECR;
      regs[ADDR_GETSTATUS_LSB]     <= RST_GETSTATUS_LSB;
      regs[ADDR_ENEC_BYTE]         <= RST_ENEC;
      regs[ADDR_DISEC_BYTE]        <= RST_DISEC;
      regs[ADDR_HJ_CFG]            <= RST_HJ_CFG;
      regs[ADDR_CRH_CFG]           <= RST_CRH_CFG;
      regs[ADDR_CRCAP1]            <= RST_CRCAP1;
      port.rdata                   <= '0;
    end
    else
    begin
      if (port.wr_en)
        regs[port.addr] <= port.wdata;                   // Immediate write
      if (port.rd_en)
        port.rdata <= regs[port.addr];                   // Registered read
      // Defining bits last so they win over a host write
      regs[ADDR_ENEC_BYTE][HJ_BIT]  <= hj_on;
      regs[ADDR_DISEC_BYTE][HJ_BIT] <= ~hj_on;
    end
  end

  // ========================================
  // Configuration mirrors
  // ========================================
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_ser_rx_tx             <= RST_TARGET[0];
      o_regf_num_frames       <= RST_NUM_FRAMES;
      o_crh_crhdly            <= RST_CRHDLY;
      o_crh_getstatus_data    <= RST_GETSTATUS_LSB;
      o_crh_crcap2            <= RST_CRCAPS2;
      o_crh_precr             <= RST_PRECR;
      o_crh_cfg_reg           <= RST_CRH_CFG;
      o_crh_tgts_count        <= RST_TGTS_COUNT;
      o_regf_ibi_cfg          <= RST_IBI_CFG;
      o_regf_ibi_payload_size <= RST_IBI_PAYLOAD;
      o_ibi_tgt_address       <= RST_ARBITRATION;
      o_regf_hj_cfg           <= RST_HJ_CFG[2:0];
      o_regf_hj_support       <= RST_CRCAP1[HJ_SUPPORT_BIT];
    end
    else
    begin
      o_ser_rx_tx             <= regs[ADDR_TARGET][0];
      o_regf_num_frames       <= regs[ADDR_NUM_FRAMES];
      o_crh_crhdly            <= regs[ADDR_CRHDLY];
      o_crh_getstatus_data    <= regs[ADDR_GETSTATUS_LSB];
      o_crh_crcap2            <= regs[ADDR_CRCAPS2];
      o_crh_precr             <= regs[ADDR_PRECR];
      o_crh_cfg_reg           <= regs[ADDR_CRH_CFG];
      o_crh_tgts_count        <= regs[ADDR_TGTS_COUNT];
      o_regf_ibi_cfg          <= regs[ADDR_IBI_CFG];
      o_regf_ibi_payload_size <= regs[ADDR_IBI_PAYLOAD];
      o_ibi_tgt_address       <= regs[ADDR_ARBITRATION];
      o_regf_hj_cfg           <= regs[ADDR_HJ_CFG][2:0];
      o_regf_hj_support       <= regs[ADDR_CRCAP1][HJ_SUPPORT_BIT];
    end
  end

endmodule

// ==== design/apb_regf_bridge.sv ====
// APB completer issuing register file port requests
`timescale 1ns/1ps

module apb_regf_bridge (
  input  logic                                 i_regf_clk,
  input  logic                                 i_regf_rst_n,
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [i3c_regf_pkg::REGF_ADDR_W-1:0] i_paddr,
  input  logic [i3c_regf_pkg::REGF_WIDTH-1:0]  i_pwdata,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_prdata,
  output logic                                 o_pready,
  output logic                                 o_pslverr,
  regf_port_if.requester                       port
);
  import i3c_regf_pkg::*;

  apb_state_e state_q;
  apb_state_e state_d;

  // Request is held through the access phase until granted
  assign port.rd_en = (state_q == AS_REQ) & ~i_pwrite;
  assign port.wr_en = (state_q == AS_REQ) & i_pwrite;
  assign port.addr  = i_paddr;
  assign port.wdata = i_pwdata;

  assign o_pready  = (state_q == AS_RESP);                  // One-cycle completion
  assign o_prdata  = (o_pready && !i_pwrite) ? port.rdata : '0;
  assign o_pslverr = 1'b0;                                  // No error responses

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      AS_IDLE: if (i_psel && !i_penable) state_d = AS_REQ;  // Setup phase seen
      AS_REQ:  if (port.host_gnt)        state_d = AS_RESP;
      AS_RESP:                           state_d = AS_IDLE;
      default:                           state_d = AS_IDLE;
    endcase
  end

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
      state_q <= AS_IDLE;
    else
      state_q <= state_d;
  end

endmodule

// ==== design/regf_port_arbiter.sv ====
// Fixed-priority sharing of the register file port with read-data return routing
`timescale 1ns/1ps

module regf_port_arbiter (
  input  logic           i_regf_clk,
  input  logic           i_regf_rst_n,
  regf_port_if.file      fetch_port,
  regf_port_if.file      host_port,
  regf_port_if.requester file_port
);
  import i3c_regf_pkg::*;

  logic                  fetch_live;
  logic                  host_live;
  logic                  fetch_rd_q;   // Fetcher owned last read
  logic                  host_rd_q;    // Host owned last read
  logic [REGF_WIDTH-1:0] fetch_hold;
  logic [REGF_WIDTH-1:0] host_hold;

  assign fetch_live = fetch_port.rd_en | fetch_port.wr_en;
  assign host_live  = host_port.rd_en | host_port.wr_en;

  assign fetch_port.host_gnt = fetch_live;  // Fetcher always wins
  assign host_port.host_gnt  = host_live & ~fetch_live;

  // Request mux
  assign file_port.rd_en = fetch_live ? fetch_port.rd_en : host_port.rd_en;
  assign file_port.wr_en = fetch_live ? fetch_port.wr_en : host_port.wr_en;
  assign file_port.addr  = fetch_live ? fetch_port.addr  : host_port.addr;
  assign file_port.wdata = fetch_live ? fetch_port.wdata : host_port.wdata;

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      fetch_rd_q <= 1'b0;
      host_rd_q  <= 1'b0;
    end
    else
    begin
      fetch_rd_q <= fetch_port.rd_en;
      host_rd_q  <= host_port.rd_en & ~fetch_live;
    end
  end

  // Each side keeps its last read until it reads again
  always_ff @(posedge i_regf_clk)
  begin
    fetch_hold <= fetch_port.rdata;
    host_hold  <= host_port.rdata;
  end

  assign fetch_port.rdata = fetch_rd_q ? file_port.rdata : fetch_hold;
  assign host_port.rdata  = host_rd_q  ? file_port.rdata : host_hold;

endmodule

// ==== design/sdr_frame_fetcher.sv ====
// SDR frame fetcher: reads target and data entries, streams bytes with valid/ready
`timescale 1ns/1ps

module sdr_frame_fetcher (
  input  logic                                i_regf_clk,
  input  logic                                i_regf_rst_n,
  input  logic                                i_fetch_start,   // One-cycle pulse
  input  logic [7:0]                          i_num_frames,
  regf_port_if.requester                      port,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0] o_frame_data,
  output logic                                o_frame_valid,
  input  logic                                i_frame_ready,
  output logic                                o_fetch_busy
);
  import i3c_regf_pkg::*;

  fetch_state_e          state_q;
  logic [7:0]            remain_q;  // Data bytes still to read
  logic [7:0]            idx_q;     // Next data entry
  logic [REGF_WIDTH-1:0] frame_q;

  // Read-only requester
  assign port.rd_en = (state_q == FS_RD_TARGET) || (state_q == FS_RD_DATA);
  assign port.wr_en = 1'b0;
  assign port.addr  = (state_q == FS_RD_TARGET) ? ADDR_TARGET : REGF_ADDR_W'(idx_q);
  assign port.wdata = '0;

  assign o_frame_data  = frame_q;
  assign o_frame_valid = (state_q == FS_SEND);
  assign o_fetch_busy  = (state_q != FS_IDLE);

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      state_q  <= FS_IDLE;
      remain_q <= '0;
      idx_q    <= '0;
    end
    else
    begin
      case (state_q)
        FS_IDLE:
          if (i_fetch_start)
          begin
            remain_q <= i_num_frames;           // Count sampled at start
            idx_q    <= 8'(ADDR_DATA_BASE);
            state_q  <= FS_RD_TARGET;
          end
        FS_RD_TARGET: if (port.host_gnt) state_q <= FS_WAIT_DATA;
        FS_RD_DATA:
          if (port.host_gnt)
          begin
            remain_q <= remain_q - 8'd1;
            idx_q    <= idx_q + 8'd1;
            state_q  <= FS_WAIT_DATA;
          end
        FS_WAIT_DATA: state_q <= FS_SEND;       // Read data lands here
        FS_SEND:                                // Stalls here under back-pressure
          if (i_frame_ready)
            state_q <= (remain_q == 8'd0) ? FS_DONE : FS_RD_DATA;
        FS_DONE: state_q <= FS_IDLE;
        default: state_q <= FS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_regf_clk)
  begin
    if (state_q == FS_WAIT_DATA)
      frame_q <= port.rdata;
  end

endmodule

// ==== design/i3c_regf_top.sv ====
// Top level: register file, port arbiter, APB bridge and SDR frame fetcher
`timescale 1ns/1ps

module i3c_regf_top (
  input  logic                                 i_regf_clk,
  input  logic                                 i_regf_rst_n,
  // APB
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [i3c_regf_pkg::REGF_ADDR_W-1:0] i_paddr,
  input  logic [i3c_regf_pkg::REGF_WIDTH-1:0]  i_pwdata,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_prdata,
  output logic                                 o_pready,
  output logic                                 o_pslverr,
  // Frame stream
  input  logic                                 i_fetch_start,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_frame_data,
  output logic                                 o_frame_valid,
  input  logic                                 i_frame_ready,
  output logic                                 o_fetch_busy,
  // Configuration
  output logic                                 o_ser_rx_tx,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_regf_num_frames,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_crh_crhdly,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_crh_getstatus_data,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_crh_crcap2,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_crh_precr,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_crh_cfg_reg,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_crh_tgts_count,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_regf_ibi_cfg,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_regf_ibi_payload_size,
  output logic [i3c_regf_pkg::REGF_WIDTH-1:0]  o_ibi_tgt_address,
  output logic [2:0]                           o_regf_hj_cfg,
  output logic                                 o_regf_hj_support
);

  regf_port_if fetch_port ();  // Fetcher side
  regf_port_if host_port ();   // APB side
  regf_port_if file_port ();   // Arbitrated port

  reg_file u_reg_file (.port(file_port), .*);

  regf_port_arbiter u_arbiter (.*);

  apb_regf_bridge u_apb_bridge (.port(host_port), .*);

  // Count comes from the mirrored NUM_FRAMES entry
  sdr_frame_fetcher u_fetcher (.port(fetch_port), .i_num_frames(o_regf_num_frames), .*);

endmodule

// ==== testbench/tb_i3c_regf_top.sv ====
// Testbench for the I3C register file top: APB driver, frame sink, write model, step table
`timescale 1ns/1ps

module tb_i3c_regf_top;
  import i3c_regf_pkg::*;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_FETCH, OP_CFG} op_e;
  typedef struct packed {
    op_e        op;
    logic [9:0] addr;
    logic [7:0] data;   // Write data, or 1 for an APB read during a fetch
    logic [7:0] exp;
  } step_t;

  logic       i_regf_clk, i_regf_rst_n;
  logic       i_psel, i_penable, i_pwrite, i_fetch_start, i_frame_ready;
  logic [9:0] i_paddr;
  logic [7:0] i_pwdata, o_prdata, o_frame_data, o_regf_num_frames, o_crh_crhdly;
  logic [7:0] o_crh_getstatus_data, o_crh_crcap2, o_crh_precr, o_crh_cfg_reg, o_crh_tgts_count;
  logic [7:0] o_regf_ibi_cfg, o_regf_ibi_payload_size, o_ibi_tgt_address;
  logic [2:0] o_regf_hj_cfg;
  logic       o_pready, o_pslverr, o_frame_valid, o_fetch_busy, o_ser_rx_tx, o_regf_hj_support;

  step_t      steps [$];
  logic [7:0] model [REGF_DEPTH];  // Expected contents, reset image plus writes
  logic [7:0] rx_q [$];            // Bytes accepted by the sink
  logic [7:0] exp_q [$];
  logic [7:0] stall_data;
  logic       stall_q;
  integer     seed;
  int         errors, cycles, limit, rnd;

  i3c_regf_top DUT (.*);

  initial
  begin
    i_regf_clk = 1'b0;
    forever #20 i_regf_clk = ~i_regf_clk;  // 40 ns period
  end

  // ========================================
  // Watchdog
  // ========================================
  always @(posedge i_regf_clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // Sink with random back-pressure, also checks valid/data hold while stalled
  initial
  begin
    forever
    begin
      @(posedge i_regf_clk);
      #2;
      if (stall_q && (!o_frame_valid || o_frame_data !== stall_data))
      begin
        $display("ERROR @%0t: stalled frame dropped or changed to %h", $time, o_frame_data);
        errors++;
      end
      rnd = $random(seed);
      i_frame_ready = (rnd[1:0] != 2'b00) && i_regf_rst_n;  // Ready about 3 of 4 cycles
      if (o_frame_valid && i_frame_ready)
        rx_q.push_back(o_frame_data);                       // Taken at the next edge
      stall_q    = o_frame_valid && !i_frame_ready;
      stall_data = o_frame_data;
    end
  end

  task automatic add_step(input op_e op, input logic [9:0] addr, input logic [7:0] data,
                          input logic [7:0] exp);
    steps.push_back({op, addr, data, exp});
  endtask

  // One APB transfer, starting and ending 2 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [9:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
    i_psel    = 1'b1;  // Setup phase
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(posedge i_regf_clk);
    #2;
    i_penable = 1'b1;
    while (!o_pready)
    begin
      @(posedge i_regf_clk);
      #2;
    end
    rdata = o_prdata;
    if (o_pslverr)
    begin
      $display("ERROR @%0t: PSLVERR high on addr %0d", $time, addr);
      errors++;
    end
    @(posedge i_regf_clk);
    #2;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    if (o_pready)
    begin
      $display("ERROR @%0t: PREADY held longer than one cycle", $time);
      errors++;
    end
  endtask

  task automatic read_check(input logic [9:0] addr, input logic [7:0] exp);
    logic [7:0] got;
    apb_access(1'b0, addr, 8'h00, got);
    if (got !== exp)
    begin
      $display("ERROR @%0t: APB read addr %0d got %h expected %h", $time, addr, got, exp);
      errors++;
    end
  endtask

  task automatic config_check(input logic [9:0] addr, input logic [7:0] exp);
    logic [7:0] got;
    case (addr)
      ADDR_TARGET:        got = {7'd0, o_ser_rx_tx};        // RnW bit only
      ADDR_NUM_FRAMES:    got = o_regf_num_frames;
      ADDR_CRHDLY:        got = o_crh_crhdly;
      ADDR_GETSTATUS_LSB: got = o_crh_getstatus_data;
      ADDR_CRCAPS2:       got = o_crh_crcap2;
      ADDR_PRECR:         got = o_crh_precr;
      ADDR_TGTS_COUNT:    got = o_crh_tgts_count;
      ADDR_CRH_CFG:       got = o_crh_cfg_reg;
      ADDR_IBI_CFG:       got = o_regf_ibi_cfg;
      ADDR_IBI_PAYLOAD:   got = o_regf_ibi_payload_size;
      ADDR_ARBITRATION:   got = o_ibi_tgt_address;
      ADDR_HJ_CFG:        got = {5'd0, o_regf_hj_cfg};
      ADDR_CRCAP1:        got = {7'd0, o_regf_hj_support};
      default:            got = 8'hxx;
    endcase
    if (got !== exp)
    begin
      $display("ERROR @%0t: config output for entry %0d is %h expected %h",
               $time, addr, got, exp);
      errors++;
    end
  endtask

  // Start a fetch, wait for busy to fall, compare the stream with the model
  task automatic run_fetch();
    int idx;
    rx_q.delete();
    exp_q.delete();
    exp_q.push_back(model[ADDR_TARGET]);
    for (int i = 0; i < int'(model[ADDR_NUM_FRAMES]); i++)
    begin
      idx = int'(ADDR_DATA_BASE) + i;
      exp_q.push_back(model[idx]);
    end
    i_fetch_start = 1'b1;
    @(posedge i_regf_clk);
    #2;
    i_fetch_start = 1'b0;
    while (o_fetch_busy)
    begin
      @(posedge i_regf_clk);
      #2;
    end
    if (rx_q.size() != exp_q.size())
    begin
      $display("ERROR @%0t: fetch gave %0d bytes expected %0d", $time, rx_q.size(),
               exp_q.size());
      errors++;
    end
    else
      foreach (exp_q[i])
        if (rx_q[i] !== exp_q[i])
        begin
          $display("ERROR @%0t: frame %0d is %h expected %h", $time, i, rx_q[i], exp_q[i]);
          errors++;
        end
  endtask

  // ========================================
  // Step table
  // ========================================
  task automatic load_table();
    add_step(OP_RD, ADDR_TARGET, 8'h00, 8'hA8);      // Reset image
    add_step(OP_RD, ADDR_ENEC_BYTE, 8'h00, 8'h03);   // ENHJ cleared, CRCAP1 is 0
    add_step(OP_RD, ADDR_DISEC_BYTE, 8'h00, 8'h08);
    add_step(OP_RD, ADDR_BDCST_WR, 8'h00, 8'hFD);
    add_step(OP_CFG, ADDR_CRHDLY, 8'h00, 8'h02);
    add_step(OP_CFG, ADDR_IBI_CFG, 8'h00, 8'h01);
    add_step(OP_CFG, ADDR_ARBITRATION, 8'h00, 8'h53);
    add_step(OP_CFG, ADDR_HJ_CFG, 8'h00, 8'h07);
    add_step(OP_CFG, ADDR_GETSTATUS_LSB, 8'h00, 8'h02);
    add_step(OP_CFG, ADDR_CRCAPS2, 8'h00, 8'h02);
    add_step(OP_CFG, ADDR_PRECR, 8'h00, 8'h02);
    add_step(OP_CFG, ADDR_TGTS_COUNT, 8'h00, 8'h02);
    add_step(OP_FETCH, 10'd0, 8'h00, 8'h00);         // A8 01 02
    add_step(OP_WR, 10'd2, 8'h5A, 8'h00);
    add_step(OP_WR, 10'd3, 8'hC3, 8'h00);
    add_step(OP_WR, 10'd4, 8'h3C, 8'h00);
    add_step(OP_RD, 10'd2, 8'h00, 8'h5A);
    add_step(OP_RD, 10'd3, 8'h00, 8'hC3);
    add_step(OP_RD, 10'd4, 8'h00, 8'h3C);
    add_step(OP_WR, ADDR_CRH_CFG, 8'h11, 8'h00);
    add_step(OP_CFG, ADDR_CRH_CFG, 8'h00, 8'h11);
    add_step(OP_WR, ADDR_IBI_PAYLOAD, 8'h20, 8'h00);
    add_step(OP_CFG, ADDR_IBI_PAYLOAD, 8'h00, 8'h20);
    add_step(OP_WR, ADDR_NUM_FRAMES, 8'h03, 8'h00);
    add_step(OP_CFG, ADDR_NUM_FRAMES, 8'h00, 8'h03);
    add_step(OP_WR, ADDR_TARGET, 8'h55, 8'h00);      // Read direction
    add_step(OP_CFG, ADDR_TARGET, 8'h00, 8'h01);
    add_step(OP_WR, ADDR_CRCAP1, 8'h01, 8'h00);      // Hot-join supported
    add_step(OP_RD, ADDR_ENEC_BYTE, 8'h00, 8'h0B);
    add_step(OP_RD, ADDR_DISEC_BYTE, 8'h00, 8'h00);
    add_step(OP_CFG, ADDR_CRCAP1, 8'h00, 8'h01);
    add_step(OP_WR, ADDR_HJ_CFG, 8'h05, 8'h00);      // Clear enable bit
    add_step(OP_RD, ADDR_ENEC_BYTE, 8'h00, 8'h03);
    add_step(OP_RD, ADDR_DISEC_BYTE, 8'h00, 8'h08);
    add_step(OP_CFG, ADDR_HJ_CFG, 8'h00, 8'h05);
    add_step(OP_FETCH, 10'd0, 8'h00, 8'h00);         // 55 5A C3 3C
    add_step(OP_FETCH, 10'd3, 8'h01, 8'hC3);         // APB read during fetch
    add_step(OP_FETCH, ADDR_IBI_PAYLOAD, 8'h01, 8'h20);
    add_step(OP_WR, ADDR_NUM_FRAMES, 8'h00, 8'h00);
    add_step(OP_FETCH, 10'd0, 8'h00, 8'h00);         // Target byte only
  endtask

  initial
  begin
    logic [7:0] dummy;
    seed = 32'h892f_e41b;
    errors = 0;
    cycles = 0;
    limit = 1000;
    stall_q = 1'b0;
    stall_data = 8'h00;
    i_regf_rst_n = 1'b0;
    {i_psel, i_penable, i_pwrite, i_fetch_start, i_frame_ready} = '0;
    i_paddr = '0;
    i_pwdata = '0;
    foreach (model[i])
      model[i] = 8'h00;
    model[0] = 8'hA8;                                 // Target, then count and data
    model[1] = 8'h02;
    model[2] = 8'h01;
    model[3] = 8'h02;
    model[4] = 8'h06;
    load_table();
    limit = 200 * steps.size();
    repeat (4) @(posedge i_regf_clk);
    #2;
    i_regf_rst_n = 1'b1;
    if (o_pready || o_frame_valid || o_fetch_busy)
    begin
      $display("ERROR @%0t: control outputs active after reset", $time);
      errors++;
    end
    for (int s = 0; s < steps.size(); s++)
    begin
      case (steps[s].op)
        OP_WR:
        begin
          apb_access(1'b1, steps[s].addr, steps[s].data, dummy);
          model[steps[s].addr] = steps[s].data;
        end
        OP_RD:  read_check(steps[s].addr, steps[s].exp);
        OP_CFG: config_check(steps[s].addr, steps[s].exp);
        default:
          if (steps[s].data[0])
            fork
              run_fetch();
              begin
                repeat (3) @(posedge i_regf_clk);  // Land inside the transfer
                #2;
                read_check(steps[s].addr, steps[s].exp);
              end
            join
          else
            run_fetch();
      endcase
    end
    $display("Run complete: %0d steps, %0d errors", steps.size(), errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
design/i3c_regf_pkg.sv
design/regf_port_if.sv
design/reg_file.sv
design/apb_regf_bridge.sv
design/regf_port_arbiter.sv
design/sdr_frame_fetcher.sv
design/i3c_regf_top.sv
testbench/tb_i3c_regf_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f flist.f --top-module tb_i3c_regf_top -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
